// File: source/pcpu_pkg.sv
`default_nettype none

package pcpu_pkg;

  localparam int word_w        = 16;     // data and instruction word
  localparam int ram_words     = 256;    // program RAM depth
  localparam int page_words    = 16;     // power of two so the page split is a bit slice
  localparam int page_count    = 16;     // physical pages in RAM
  localparam int page_idx_w    = 4;      // page index and logical segment width
  localparam int reg_count     = 16;     // general registers
  localparam int program_start = 0;      // logical word address of the first instruction
  localparam int fifo_depth    = 16;     // trace bytes buffered ahead of the serializer
  localparam int clk_per_bit   = 8;      // short bit time for simulation

  localparam logic [7:0] trace_fault = 8'h21;  // trace byte sent instead of an opcode

  // opcode sits in the high byte of the first instruction word
  typedef enum logic [7:0] {
    op_jmp          = 8'd1,    // pc <= operand
    op_num2reg_low  = 8'd16,   // reg <= operand
    op_reg_low_plus = 8'd18,   // reg <= reg + operand
    op_exit         = 8'd30    // stop the core
  } opcode_e;

  // host address map, paddr[15:14]
  typedef enum logic [1:0] {
    region_ram  = 2'd0,  // program words
    region_mmu  = 2'd1,  // chain and segment tables
    region_reg  = 2'd2,  // register file, read only
    region_ctrl = 2'd3   // start, start page, status
  } apb_region_e;

endpackage

`default_nettype wire

// File: source/program_ram.sv
`timescale 1ns/1ns
`default_nettype none

module program_ram import pcpu_pkg::*; (
  input  wire                         clk,
  input  wire                         we,
  input  wire [$clog2(ram_words)-1:0] addr,
  input  wire [word_w-1:0]            wdata,
  output logic [word_w-1:0]           rdata
);

  logic [word_w-1:0] mem [ram_words];  // program words

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];  // old word on a write cycle
  end

endmodule

`default_nettype wire

// File: source/ram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module ram_arbiter import pcpu_pkg::*; (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          host_req,
  input  wire                          host_we,
  input  wire [$clog2(ram_words)-1:0]  host_addr,
  input  wire [word_w-1:0]             host_wdata,
  input  wire                          core_req,
  input  wire [$clog2(ram_words)-1:0]  core_addr,
  output logic                         host_gnt,
  output logic                         core_gnt,
  output logic                         ram_we,
  output logic [$clog2(ram_words)-1:0] ram_addr,
  output logic [word_w-1:0]            ram_wdata
);

  logic host_last;  // host took the RAM last cycle and is collecting its data
  logic core_last;  // same for the core

  always_comb begin
    host_gnt  = host_req && !host_last;              // host wins every tie
    core_gnt  = core_req && !core_last && !host_gnt;
    ram_we    = host_gnt && host_we;                 // core only reads
    ram_addr  = host_gnt ? host_addr : core_addr;
    ram_wdata = host_wdata;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      host_last <= 1'b0;
      core_last <= 1'b0;
    end else begin
      host_last <= host_gnt;  // rdata for this owner is valid now
      core_last <= core_gnt;
    end
  end

endmodule

`default_nettype wire

// File: source/page_walker.sv
`timescale 1ns/1ns
`default_nettype none

module page_walker import pcpu_pkg::*; (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          tbl_we,
  input  wire [page_idx_w-1:0]         tbl_idx,
  input  wire [2*page_idx_w-1:0]       tbl_wdata,
  input  wire                          start,
  input  wire [page_idx_w-1:0]         start_page,
  output logic [2*page_idx_w-1:0]      tbl_rdata,
  input  wire                          xl_req,
  input  wire [$clog2(ram_words)-1:0]  logical_addr,
  output logic                         xl_done,
  output logic                         xl_fault,
  output logic [$clog2(ram_words)-1:0] phys_addr
);

  localparam int addr_w = $clog2(ram_words);
  localparam int off_w  = $clog2(page_words);

  logic [page_idx_w-1:0] chain_tbl [page_count];  // next page, points to itself at chain end
  logic [page_idx_w-1:0] seg_tbl   [page_count];  // logical segment held by each page
  logic [page_idx_w-1:0] pos;                     // page under test
  logic                  busy;                    // walk in progress
  logic [page_idx_w-1:0] seg;
  logic [off_w-1:0]      off;
  logic                  hit;

  assign seg       = logical_addr[addr_w-1:off_w];
  assign off       = logical_addr[off_w-1:0];
  assign hit       = seg_tbl[pos] == seg;
  assign tbl_rdata = {chain_tbl[tbl_idx], seg_tbl[tbl_idx]};

  always_ff @(posedge clk) begin
    if (tbl_we) begin
      chain_tbl[tbl_idx] <= tbl_wdata[2*page_idx_w-1:page_idx_w];
      seg_tbl[tbl_idx]   <= tbl_wdata[page_idx_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && xl_req) begin
      pos       <= chain_tbl[start_page];  // first hop past the start page
      phys_addr <= {start_page, off};      // final for segment 0
    end else if (busy) begin
      pos       <= chain_tbl[pos];
      phys_addr <= {pos, off};             // kept once hit ends the walk
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      xl_done  <= 1'b0;
      xl_fault <= 1'b0;
    end else begin
      xl_done  <= 1'b0;
      xl_fault <= 1'b0;
      if (start) begin
        busy <= 1'b0;                       // new run drops any stale walk
      end else if (!busy && xl_req) begin
        busy    <= seg != '0;
        xl_done <= seg == '0;               // segment 0 is the start page
      end else if (busy) begin
        if (hit) begin
          busy    <= 1'b0;
          xl_done <= 1'b1;
        end else if (chain_tbl[pos] == pos) begin
          busy     <= 1'b0;                 // chain end without a match
          xl_fault <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core import pcpu_pkg::*; (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          start,
  output logic                         running,
  output logic                         fault,
  output logic                         xl_req,
  output logic [$clog2(ram_words)-1:0] logical_addr,
  input  wire                          xl_done,
  input  wire                          xl_fault,
  input  wire [$clog2(ram_words)-1:0]  phys_addr,
  output logic                         core_req,
  output logic [$clog2(ram_words)-1:0] core_addr,
  input  wire                          core_gnt,
  input  wire [word_w-1:0]             ram_rdata,
  input  wire [$clog2(reg_count)-1:0]  reg_rd_idx,
  output logic [word_w-1:0]            reg_rd_data,
  output logic                         trace_push,
  output logic [7:0]                   trace_byte,
  input  wire                          trace_full
);

  localparam int addr_w = $clog2(ram_words);
  localparam int ri_w   = $clog2(reg_count);

  typedef enum logic [2:0] {
    st_idle, st_xl1, st_fetch1, st_xl2, st_fetch2, st_exec, st_trace
  } state_e;

  state_e            state;
  logic [addr_w-1:0] pc;                 // logical word address
  logic [word_w-1:0] instr;              // opcode and register byte
  logic [word_w-1:0] operand;            // second word
  logic              rd_wait;            // granted, word arrives this cycle
  logic              halt;               // leave after the trace byte
  logic [word_w-1:0] regs [reg_count];
  opcode_e           op;
  logic [ri_w-1:0]   ri;

  assign op           = opcode_e'(instr[15:8]);
  assign ri           = instr[ri_w-1:0];
  assign running      = state != st_idle;
  assign logical_addr = pc;
  assign core_addr    = phys_addr;       // walker holds it until the next request
  assign core_req     = (state == st_fetch1 || state == st_fetch2) && !rd_wait;
  assign trace_push   = state == st_trace && !trace_full;  // wait out back-pressure
  assign reg_rd_data  = regs[reg_rd_idx];

  always_ff @(posedge clk) begin
    if (state == st_fetch1 && rd_wait) begin
      instr <= ram_rdata;
    end
    if (state == st_fetch2 && rd_wait) begin
      operand <= ram_rdata;
    end
    if (state == st_idle && start) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (state == st_exec) begin
      case (op)
        op_num2reg_low:  regs[ri] <= operand;
        op_reg_low_plus: regs[ri] <= regs[ri] + operand;  // wraps at 2^16
        default: ;
      endcase
    end
    if (state == st_exec) begin
      trace_byte <= instr[15:8];         // raw byte, unknown opcodes traced too
    end else if ((state == st_xl1 || state == st_xl2) && xl_fault) begin
      trace_byte <= trace_fault;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      pc      <= '0;
      rd_wait <= 1'b0;
      halt    <= 1'b0;
      fault   <= 1'b0;
      xl_req  <= 1'b0;
    end else begin
      xl_req <= 1'b0;                    // one-cycle request pulse
      case (state)
        st_idle: if (start) begin
          pc     <= addr_w'(program_start);
          fault  <= 1'b0;
          halt   <= 1'b0;
          xl_req <= 1'b1;
          state  <= st_xl1;
        end
        st_xl1, st_xl2: if (xl_fault) begin
          fault <= 1'b1;
          halt  <= 1'b1;
          state <= st_trace;              // report the fault, then stop
        end else if (xl_done) begin
          state <= (state == st_xl1) ? st_fetch1 : st_fetch2;
        end
        st_fetch1, st_fetch2: if (rd_wait) begin
          rd_wait <= 1'b0;
          pc      <= pc + 1'b1;
          if (state == st_fetch1) begin
            xl_req <= 1'b1;               // second word may sit on the next page
            state  <= st_xl2;
          end else begin
            state <= st_exec;
          end
        end else if (core_gnt) begin
          rd_wait <= 1'b1;
        end
        st_exec: begin
          if (op == op_jmp) begin
            pc <= operand[addr_w-1:0];
          end
          if (op == op_exit) begin
            halt <= 1'b1;
          end
          state <= st_trace;
        end
        st_trace: if (!trace_full) begin
          if (halt) begin
            state <= st_idle;
          end else begin
            xl_req <= 1'b1;
            state  <= st_xl1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/apb_host_port.sv
`timescale 1ns/1ns
`default_nettype none

module apb_host_port import pcpu_pkg::*; (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire [15:0]                   paddr,
  input  wire [word_w-1:0]             pwdata,
  output logic [word_w-1:0]            prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         host_req,
  output logic                         host_we,
  output logic [$clog2(ram_words)-1:0] host_addr,
  output logic [word_w-1:0]            host_wdata,
  input  wire                          host_gnt,
  input  wire [word_w-1:0]             ram_rdata,
  output logic                         tbl_we,
  output logic [page_idx_w-1:0]        tbl_idx,
  output logic [2*page_idx_w-1:0]      tbl_wdata,
  input  wire [2*page_idx_w-1:0]       tbl_rdata,
  output logic [$clog2(reg_count)-1:0] reg_rd_idx,
  input  wire [word_w-1:0]             reg_rd_data,
  output logic                         start,
  output logic [page_idx_w-1:0]        start_page,
  input  wire                          running,
  input  wire                          fault
);

  apb_region_e region;
  logic        access;   // APB access phase
  logic        locked;   // RAM or table write refused while the core runs
  logic        granted;  // RAM word valid this cycle
  logic        ctrl_wr;

  assign region     = apb_region_e'(paddr[15:14]);
  assign access     = psel && penable;
  assign locked     = pwrite && running && (region == region_ram || region == region_mmu);
  assign ctrl_wr    = access && pwrite && region == region_ctrl && !running;
  assign host_req   = access && region == region_ram && !granted && !locked;
  assign host_we    = pwrite;
  assign host_addr  = paddr[$clog2(ram_words)-1:0];
  assign host_wdata = pwdata;
  assign tbl_we     = access && pwrite && region == region_mmu && !locked;
  assign tbl_idx    = paddr[page_idx_w-1:0];
  assign tbl_wdata  = pwdata[2*page_idx_w-1:0];  // chain entry over segment
  assign reg_rd_idx = paddr[$clog2(reg_count)-1:0];

  always_comb begin
    pready  = access && (region != region_ram || granted || locked);
    pslverr = access && ((pwrite && region == region_reg) || locked);
    case (region)
      region_ram: prdata = ram_rdata;
      region_mmu: prdata = word_w'(tbl_rdata);
      region_reg: prdata = reg_rd_data;
      default:    prdata = word_w'({start_page, 2'b00, fault, running});
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      granted    <= 1'b0;
      start      <= 1'b0;
      start_page <= '0;
    end else begin
      granted <= host_gnt;                 // data follows the grant by one cycle
      start   <= ctrl_wr && pwdata[0];     // single pulse, access lasts one cycle
      if (ctrl_wr) begin
        start_page <= pwdata[7:4];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/trace_uart.sv
`timescale 1ns/1ns
`default_nettype none

module trace_uart import pcpu_pkg::*; (
  input  wire       clk,
  input  wire       arst_n,
  input  wire       trace_push,
  input  wire [7:0] trace_byte,
  output logic      trace_full,
  output logic      tx
);

  localparam int ptr_w  = $clog2(fifo_depth);
  localparam int tick_w = $clog2(clk_per_bit);

  typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;

  logic [7:0]        fifo [fifo_depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [ptr_w:0]    count;     // bytes waiting
  logic              pop;
  tx_state_e         state;
  logic [7:0]        shreg;     // byte on the line, LSB out first
  logic [tick_w-1:0] tick;      // clocks into the current bit
  logic [2:0]        nbit;
  logic              bit_end;

  assign trace_full = count == (ptr_w+1)'(fifo_depth);
  assign pop        = state == tx_idle && count != '0;
  assign bit_end    = tick == tick_w'(clk_per_bit - 1);

  always_ff @(posedge clk) begin
    if (trace_push) begin
      fifo[wr_ptr] <= trace_byte;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      state  <= tx_idle;
      shreg  <= '0;
      tick   <= '0;
      nbit   <= '0;
      tx     <= 1'b1;                  // line idles high
    end else begin
      if (trace_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      count <= count + trace_push - pop;
      tick  <= (bit_end || state == tx_idle) ? '0 : tick + 1'b1;
      case (state)
        tx_idle: if (pop) begin
          shreg  <= fifo[rd_ptr];
          rd_ptr <= rd_ptr + 1'b1;
          tx     <= 1'b0;              // start bit
          state  <= tx_start;
        end
        tx_start: if (bit_end) begin
          tx    <= shreg[0];
          nbit  <= '0;
          state <= tx_data;
        end
        tx_data: if (bit_end) begin
          shreg <= shreg >> 1;
          tx    <= shreg[1];
          nbit  <= nbit + 1'b1;
          if (nbit == 3'd7) begin
            tx    <= 1'b1;             // stop bit
            state <= tx_stop;
          end
        end
        tx_stop: if (bit_end) begin
          state <= tx_idle;
        end
        default: state <= tx_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/pcpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module pcpu_top import pcpu_pkg::*; (
  input  wire               clk,
  input  wire               arst_n,
  input  wire               psel,
  input  wire               penable,
  input  wire               pwrite,
  input  wire [15:0]        paddr,
  input  wire [word_w-1:0]  pwdata,
  output logic [word_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              tx
);

  localparam int addr_w = $clog2(ram_words);

  logic                         host_req, host_we, host_gnt;
  logic [addr_w-1:0]            host_addr;
  logic [word_w-1:0]            host_wdata;
  logic                         core_req, core_gnt;
  logic [addr_w-1:0]            core_addr;
  logic                         ram_we;
  logic [addr_w-1:0]            ram_addr;
  logic [word_w-1:0]            ram_wdata, ram_rdata;   // shared read bus
  logic                         tbl_we;
  logic [page_idx_w-1:0]        tbl_idx, start_page;
  logic [2*page_idx_w-1:0]      tbl_wdata, tbl_rdata;
  logic [$clog2(reg_count)-1:0] reg_rd_idx;
  logic [word_w-1:0]            reg_rd_data;
  logic                         start, running, fault;
  logic                         xl_req, xl_done, xl_fault;
  logic [addr_w-1:0]            logical_addr, phys_addr;
  logic                         trace_push, trace_full;
  logic [7:0]                   trace_byte;

  program_ram ram_i (.clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata));

  ram_arbiter   arb_i (.*);
  page_walker   mmu_i (.*);
  cpu_core      cpu_i (.*);
  apb_host_port apb_i (.*);
  trace_uart    uart_i (.*);

endmodule

`default_nettype wire

// File: tb/tb_uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_rx import pcpu_pkg::*; (
  input  wire         clk,
  input  wire         rx,
  output logic [7:0]  rx_byte,    // last complete byte
  output logic [15:0] rx_count,   // bumps once per received byte
  output logic        frame_err   // sticky, stop bit seen low
);

  logic [7:0] shift;

  initial begin
    rx_byte   = '0;
    rx_count  = '0;
    frame_err = 1'b0;
    shift     = '0;
    forever begin
      @(negedge rx);                             // leading edge of the start bit
      repeat (clk_per_bit / 2) @(posedge clk);   // move to mid bit
      if (!rx) begin
        for (int i = 0; i < 8; i++) begin
          repeat (clk_per_bit) @(posedge clk);
          shift[i] = rx;                         // lsb first
        end
        repeat (clk_per_bit) @(posedge clk);     // middle of the stop bit
        if (rx) begin
          rx_byte  = shift;
          rx_count = rx_count + 1'b1;            // byte first, then the count
        end else begin
          frame_err = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_pcpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pcpu import pcpu_pkg::*; ();

  localparam int seed          = 93354;
  localparam int apb_timeout   = 50;      // cycles waiting on pready
  localparam int halt_polls    = 1000;    // status reads before giving up
  localparam int trace_timeout = 40000;   // cycles waiting on tx bytes

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [15:0] pwdata;
  logic [15:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        tx;
  logic [7:0]  rx_byte;
  logic [15:0] rx_count;
  logic        frame_err;

  logic [15:0] lmem [256];      // program as the core sees it, logical addresses
  bit          mapped [16];     // logical segment reachable
  int          seg_page [16];   // physical page of each mapped segment
  int          lpc;             // next logical address to place an instruction
  logic [15:0] exp_regs [16];
  logic [7:0]  exp_trace [$];
  logic        exp_fault;
  logic [7:0]  got_trace [$];   // every byte decoded from tx
  int          full_cycles;     // cycles with the trace FIFO full

  pcpu_top dut_i (
    .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .tx
  );

  tb_uart_rx rx_i (.clk, .rx(tx), .rx_byte, .rx_count, .frame_err);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial full_cycles = 0;

  always @(posedge clk) if (dut_i.trace_full) full_cycles++;  // back-pressure seen

  always @(rx_count) if (rx_count != 0) got_trace.push_back(rx_byte);

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else
      stop_on_error($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
  endtask

  // one APB transfer, setup then access until pready
  task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
                          output logic [15:0] rdata, output logic err);
    int waited;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);                    // outputs settled, next edge samples them
    while (!pready) begin
      waited++;
      if (waited > apb_timeout)
        stop_on_error($sformatf("no pready on the APB access to address %h", addr));
      else
        @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_ok(input logic [15:0] addr, input logic [15:0] data);
    logic [15:0] d;
    logic        err;
    apb_xfer(1'b1, addr, data, d, err);
    check_val("pslverr", 16'(err), 16'h0);
  endtask

  task automatic read_ok(input logic [15:0] addr, output logic [15:0] data);
    logic err;
    apb_xfer(1'b0, addr, 16'h0, data, err);
    check_val("pslverr", 16'(err), 16'h0);
  endtask

  task automatic mmu_entry(input int idx, input int chain, input int seg);
    logic [15:0] d;
    logic [15:0] entry;
    entry = 16'({chain[3:0], seg[3:0]});   // chain over segment
    write_ok(16'h4000 | 16'(idx), entry);
    read_ok(16'h4000 | 16'(idx), d);
    check_val("tbl_rdata", d, entry);
  endtask

  task automatic reset_tables();
    for (int i = 0; i < 16; i++) begin
      mmu_entry(i, i, 0);                // every page ends its own chain
      mapped[i] = 1'b0;
    end
  endtask

  task automatic map_seg(input int seg, input int page);
    mapped[seg]   = 1'b1;
    seg_page[seg] = page;
  endtask

  task automatic store_word(input int l, input logic [15:0] w);
    lmem[l] = w;
    write_ok(16'(seg_page[l >> 4] * 16 + (l & 15)), w);
  endtask

  task automatic put_instr(input logic [7:0] op, input logic [7:0] ri, input logic [15:0] arg);
    store_word(lpc, {op, ri});
    store_word(lpc + 1, arg);
    lpc += 2;
  endtask

  // reference execution straight from the opcode rules
  function automatic void run_model();
    logic [7:0]  pc;
    logic [15:0] w1;
    logic [15:0] w2;
    logic [7:0]  pc_next;
    bit          stop;
    int          steps;
    foreach (exp_regs[i]) exp_regs[i] = '0;
    exp_trace.delete();
    exp_fault = 1'b0;
    pc        = 8'(program_start);
    stop      = 1'b0;
    steps     = 0;
    while (!stop && steps < 200) begin
      steps++;
      pc_next = pc + 1'b1;
      if (!mapped[pc[7:4]] || !mapped[pc_next[7:4]]) begin
        exp_trace.push_back(trace_fault);   // either word may miss the chain
        exp_fault = 1'b1;
        stop      = 1'b1;
      end else begin
        w1 = lmem[pc];
        w2 = lmem[pc_next];
        pc = pc_next + 1'b1;
        case (w1[15:8])
          op_num2reg_low:  exp_regs[w1[3:0]] = w2;
          op_reg_low_plus: exp_regs[w1[3:0]] = exp_regs[w1[3:0]] + w2;
          op_jmp:          pc = w2[7:0];
          op_exit:         stop = 1'b1;
          default: ;
        endcase
        exp_trace.push_back(w1[15:8]);
      end
    end
  endfunction

  task automatic run_and_check(input logic [3:0] page, input bit probe_lock);
    logic [15:0] st;
    logic [15:0] d;
    logic        err;
    int          polls;
    int          waited;
    int          base;
    run_model();
    base = got_trace.size();
    write_ok(16'hC000, {8'h00, page, 4'h1});
    if (probe_lock) begin
      apb_xfer(1'b1, 16'h00FF, 16'hDEAD, d, err);   // RAM is locked while running
      check_val("pslverr", 16'(err), 16'h1);
    end
    polls = 0;
    do begin
      if (polls > halt_polls) stop_on_error("core still running after the status poll limit");
      polls++;
      read_ok(16'hC000, st);
    end while (st[0]);
    check_val("fault", 16'(st[1]), 16'(exp_fault));
    check_val("start_page", 16'(st[7:4]), 16'(page));
    waited = 0;
    while (got_trace.size() - base < exp_trace.size()) begin
      waited++;
      if (waited > trace_timeout) stop_on_error("trace bytes missing on tx");
      else @(posedge clk);
    end
    repeat (20 * clk_per_bit) @(posedge clk);      // room for a stray extra byte
    check_val("trace count", 16'(got_trace.size() - base), 16'(exp_trace.size()));
    foreach (exp_trace[i])
      check_val($sformatf("trace byte %0d", i), 16'(got_trace[base + i]), 16'(exp_trace[i]));
    check_val("frame_err", 16'(frame_err), 16'h0);
    for (int i = 0; i < 16; i++) begin
      read_ok(16'h8000 | 16'(i), d);
      check_val($sformatf("r%0d", i), d, exp_regs[i]);
    end
  endtask

  initial begin
    logic [15:0] d;
    logic        err;
    logic [15:0] words [8];
    void'($urandom(seed));
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    arst_n  = 1'b0;
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;
    check_val("pready", 16'(pready), 16'h0);
    check_val("pslverr", 16'(pslverr), 16'h0);
    check_val("tx", 16'(tx), 16'h1);

    // RAM write and readback, then a refused register write
    foreach (words[i]) begin
      words[i] = 16'($urandom);
      write_ok(16'(i * 37 + 5), words[i]);
    end
    foreach (words[i]) begin
      read_ok(16'(i * 37 + 5), d);
      check_val("ram_rdata", d, words[i]);
    end
    apb_xfer(1'b1, 16'h8003, 16'h1234, d, err);
    check_val("pslverr", 16'(err), 16'h1);

    // straight line program inside segment 0
    reset_tables();
    map_seg(0, 4);
    lpc = 0;
    for (int i = 0; i < 3; i++) put_instr(op_num2reg_low, 8'(4 * i + 1), 16'($urandom));
    for (int i = 0; i < 3; i++) put_instr(op_reg_low_plus, 8'(4 * i + 1), 16'($urandom));
    put_instr(op_reg_low_plus, 8'd1, 16'($urandom));
    put_instr(op_exit, 8'd0, 16'h0);
    run_and_check(4'd4, 1'b0);

    // segment 1 two hops down the chain, segment 2 one hop further
    reset_tables();
    mmu_entry(3, 7, 0);
    mmu_entry(7, 5, 14);
    mmu_entry(5, 2, 1);
    mmu_entry(2, 2, 2);
    map_seg(0, 3);
    map_seg(1, 5);
    map_seg(2, 2);
    lpc = 0;
    put_instr(op_num2reg_low, 8'd1, 16'($urandom));
    put_instr(op_reg_low_plus, 8'd1, 16'($urandom));
    put_instr(op_jmp, 8'd0, 16'd13);
    lpc = 13;
    put_instr(op_num2reg_low, 8'd2, 16'($urandom));
    put_instr(op_reg_low_plus, 8'd2, 16'($urandom));    // straddles segments 0 and 1
    put_instr(op_num2reg_low, 8'd3, 16'($urandom));
    put_instr(op_jmp, 8'd0, 16'd37);                      // segment 2, offset 5
    lpc = 37;
    put_instr(op_reg_low_plus, 8'd3, 16'($urandom));
    put_instr(op_exit, 8'd0, 16'h0);
    run_and_check(4'd3, 1'b0);

    // jump into a segment that no chain entry holds
    reset_tables();
    map_seg(0, 6);
    lpc = 0;
    put_instr(op_num2reg_low, 8'd2, 16'($urandom));
    put_instr(op_jmp, 8'd0, 16'h0030);
    run_and_check(4'd6, 1'b0);
    check_val("last trace byte", 16'(got_trace[$]), 16'(trace_fault));

    // long program over four segments, the trace FIFO has to fill
    reset_tables();
    mmu_entry(8, 9, 0);
    mmu_entry(9, 10, 1);
    mmu_entry(10, 11, 2);
    mmu_entry(11, 11, 3);
    for (int s = 0; s < 4; s++) map_seg(s, 8 + s);
    lpc = 0;
    for (int i = 0; i < 29; i++)
      put_instr(($urandom % 2) ? op_reg_low_plus : op_num2reg_low, 8'($urandom % 16),
                16'($urandom));
    put_instr(op_exit, 8'd0, 16'h0);
    run_and_check(4'd8, 1'b1);
    check_val("trace_full seen", 16'(full_cycles != 0), 16'h1);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/pcpu_pkg.sv
source/program_ram.sv
source/ram_arbiter.sv
source/page_walker.sv
source/cpu_core.sv
source/apb_host_port.sv
source/trace_uart.sv
source/pcpu_top.sv
tb/tb_uart_rx.sv
tb/tb_pcpu.sv

// File: Makefile
TOP := tb_pcpu

all: run

obj_dir/V$(TOP): vlog.f $(wildcard source/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
